// File: Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal -f filelist.f \
		--top-module conv_tb -o Vconv_tb

run: compile
	./obj_dir/Vconv_tb | tee sim.log
	grep -q "^sim passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

// File: bench/conv_tb.sv
`timescale 1ns/1ps

module conv_tb;

    localparam int H = 28;
    localparam int W = 28;
    localparam int NPIX = H * W;
    localparam logic [11:0] CTRL = 12'hc00;
    localparam logic [11:0] STATUS = 12'hc01;

    // two runs at 12 cycles per position, bus traffic at 3 cycles per access
    localparam int RUN_CYCLES = 2 * NPIX * 12;
    localparam int BUS_CYCLES = 3 * (2 * (2 * NPIX + 9) + 64);
    localparam int TIMEOUT_CYCLES = RUN_CYCLES + BUS_CYCLES + 5000;
    localparam int POLL_LIMIT = NPIX * 12 / 2;

    logic clk;
    logic rst;
    logic cyc;
    logic stb;
    logic we;
    logic [11:0] adr;
    logic [31:0] dat_i;
    logic [31:0] dat_o;
    logic ack;

    logic [7:0] img [NPIX];
    logic signed [7:0] ker [9];
    int probe [9] = '{-128, -5, -1, 0, 1, 7, 127, 64, -64};
    logic [31:0] lfsr = 32'ha082_7e29;

    int unsigned cycle_cnt = 0;
    int unsigned run_start;
    int unsigned run_len [2];

    int value_errs = 0;
    int bus_errs = 0;
    int proto_errs = 0;
    int run_errs = 0;

    tb_clock #(.PERIOD(4)) i_clock (.clk(clk));

    conv_top #(.H(H), .W(W)) i_dut (
        .clk(clk), .rst(rst), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
        .dat_i(dat_i), .dat_o(dat_o), .ack(ack)
    );

    always @(posedge clk)
        cycle_cnt <= cycle_cnt + 1;

    // wishbone classic handshake
    ack_after_stb: assert property (@(posedge clk) disable iff (!rst)
        cyc && stb && !ack |=> ack)
    else
    begin
        $display("[ERROR] %0t ack did not follow stb by one cycle", $time);
        proto_errs++;
    end

    ack_one_cycle: assert property (@(posedge clk) disable iff (!rst) ack |=> !ack)
    else
    begin
        $display("[ERROR] %0t ack held longer than one cycle", $time);
        proto_errs++;
    end

    ack_needs_stb: assert property (@(posedge clk) disable iff (!rst)
        ack |-> $past(cyc && stb))
    else
    begin
        $display("[ERROR] %0t ack without a preceding stb", $time);
        proto_errs++;
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [7:0] random_byte();
        logic [7:0] b;
        for (int k = 0; k < 8; k++)
        begin
            lfsr = lfsr_step(lfsr);
            b[k] = lfsr[0];  // one step per bit
        end
        return b;
    endfunction

    // zero padded 3x3 sum at (i, j)
    function automatic int expected_sum(input int i, input int j);
        int sum;
        int r;
        int c;
        sum = 0;
        for (int dr = -1; dr <= 1; dr++)
        begin
            for (int dc = -1; dc <= 1; dc++)
            begin
                r = i + dr;
                c = j + dc;
                if (r >= 0 && r < H && c >= 0 && c < W)
                    sum += int'(img[r * W + c]) * int'(ker[(dr + 1) * 3 + dc + 1]);
            end
        end
        return sum;
    endfunction

    // 255 per in-image neighbour for a flat image of unit weights
    function automatic int flat_sum(input int i, input int j);
        int rows;
        int cols;
        rows = (i == 0 || i == H - 1) ? 2 : 3;
        cols = (j == 0 || j == W - 1) ? 2 : 3;
        return rows * cols * 255;
    endfunction

    task automatic access_bus(input logic wr, input logic [11:0] a, input logic [31:0] wd,
                              output logic [31:0] rd);
        int waited;
        @(posedge clk);
        #1;
        cyc = 1'b1;
        stb = 1'b1;
        we = wr;
        adr = a;
        dat_i = wd;
        waited = 0;
        rd = '0;
        do
        begin
            @(posedge clk);
            #1;
            waited++;
        end while (!ack && waited < 8);
        if (ack)
            rd = dat_o;
        else
        begin
            $display("no ack from the DUT for the access at address %h", a);
            bus_errs++;
        end
        cyc = 1'b0;
        stb = 1'b0;
        we = 1'b0;
    endtask

    task automatic write_word(input logic [11:0] a, input logic [31:0] d);
        logic [31:0] unused;
        access_bus(1'b1, a, d, unused);
    endtask

    task automatic read_word(input logic [11:0] a, output logic [31:0] d);
        access_bus(1'b0, a, '0, d);
    endtask

    task automatic expect_word(input logic [11:0] a, input logic [31:0] exp, input string what);
        logic [31:0] got;
        read_word(a, got);
        assert (got == exp)
        else
        begin
            $display("[ERROR] %0t %s read %h expected %h", $time, what, got, exp);
            value_errs++;
        end
    endtask

    task automatic load_image();
        for (int k = 0; k < NPIX; k++)
            write_word({2'd0, 10'(k)}, {24'd0, img[k]});
    endtask

    task automatic load_kernel();
        for (int k = 0; k < 9; k++)
            write_word({2'd2, 6'd0, 4'(k)}, {24'd0, ker[k]});
    endtask

    // start, then status must show busy with done cleared
    task automatic start_run();
        write_word(CTRL, 32'h1);
        run_start = cycle_cnt;
        expect_word(STATUS, 32'h1, "status after start");
    endtask

    task automatic wait_done();
        logic [31:0] st;
        int polls;
        st = '0;
        polls = 0;
        while (!st[1] && polls < POLL_LIMIT)
        begin
            read_word(STATUS, st);
            polls++;
        end
        if (!st[1])
        begin
            $display("the run did not complete, done was never set");
            run_errs++;
        end
        else
            expect_word(STATUS, 32'h2, "status at end of run");
    endtask

    task automatic check_results(input bit flat);
        logic [31:0] data;
        int got;
        for (int i = 0; i < H; i++)
        begin
            for (int j = 0; j < W; j++)
            begin
                read_word({2'd1, 10'(i * W + j)}, data);
                got = data;  // sign-extended by the DUT
                assert (got == expected_sum(i, j))
                else
                begin
                    $display("[ERROR] %0t result (%0d,%0d) is %0d, expected %0d",
                             $time, i, j, got, expected_sum(i, j));
                    value_errs++;
                end
                if (flat)
                begin
                    assert (got == flat_sum(i, j))
                    else
                    begin
                        $display("[ERROR] %0t flat result (%0d,%0d) is %0d, expected %0d",
                                 $time, i, j, got, flat_sum(i, j));
                        value_errs++;
                    end
                end
            end
        end
    endtask

    initial
    begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, the test hung", TIMEOUT_CYCLES);
        $display("sim failed");
        $finish;
    end

    initial
    begin
        rst = 1'b0;
        cyc = 1'b0;
        stb = 1'b0;
        we = 1'b0;
        adr = '0;
        dat_i = '0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b1;

        // idle state and kernel registers after reset
        expect_word(STATUS, 32'h0, "status after reset");
        for (int k = 0; k < 9; k++)
            expect_word({2'd2, 6'd0, 4'(k)}, 32'h0, "kernel slot after reset");
        for (int k = 0; k < 9; k++)
        begin
            write_word({2'd2, 6'd0, 4'(k)}, {24'd0, 8'(probe[k])});
            expect_word({2'd2, 6'd0, 4'(k)}, 32'(probe[k]), "kernel readback");
        end

        // first run with a random image and kernel
        for (int k = 0; k < NPIX; k++)
            img[k] = random_byte();
        for (int k = 0; k < 9; k++)
            ker[k] = random_byte();
        load_image();
        load_kernel();
        start_run();
        repeat (NPIX * 2) @(posedge clk);  // well into the run
        expect_word(STATUS, 32'h1, "status during run");
        write_word(CTRL, 32'h1);  // ignored while busy
        write_word({2'd0, 10'(NPIX - 1)}, {24'd0, ~img[NPIX - 1]});  // dropped
        wait_done();
        run_len[0] = cycle_cnt - run_start;
        check_results(1'b0);

        // second run with a new image and kernel
        for (int k = 0; k < NPIX; k++)
            img[k] = 8'hff;
        for (int k = 0; k < 9; k++)
            ker[k] = 8'sd1;
        load_image();
        load_kernel();
        start_run();
        wait_done();
        run_len[1] = cycle_cnt - run_start;
        check_results(1'b1);

        // same schedule in both runs, an accepted second start would stretch the first
        assert (run_len[0] <= run_len[1] + 8)
        else
        begin
            $display("[ERROR] %0t first run took %0d cycles, second run %0d",
                     $time, run_len[0], run_len[1]);
            run_errs++;
        end

        $display("errors: value %0d, bus %0d, protocol %0d, run %0d",
                 value_errs, bus_errs, proto_errs, run_errs);
        if (value_errs + bus_errs + proto_errs + run_errs == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

// File: bench/tb_clock.sv
`timescale 1ns/1ps

module tb_clock
#(
    parameter int PERIOD = 4  // ns
)
(
    output logic clk
);

    initial
    begin
        clk = 1'b0;
        forever
            #(PERIOD / 2) clk = ~clk;
    end

endmodule

// File: filelist.f
logic/conv_pkg.sv
logic/dual_port_ram.sv
logic/patch_addr_gen.sv
logic/window_fetch.sv
logic/mac_unit.sv
logic/conv_ctrl.sv
logic/wb_conv_regs.sv
logic/conv_top.sv
bench/tb_clock.sv
bench/conv_tb.sv

// File: logic/conv_ctrl.sv
`timescale 1ns/1ps

module conv_ctrl
#(
    parameter int H = 28,
    parameter int W = 28
)
(
    input  logic            clk,
    input  logic            rst,
    input  logic            start,
    input  logic            window_valid,
    input  logic            result_valid,
    output conv_pkg::pos_t  pos,
    output logic            pos_valid,
    output logic            restart,
    output logic            res_we,
    output conv_pkg::addr_t res_waddr,
    output logic            busy,
    output logic            done
);

    localparam logic [4:0] LAST_I = 5'(H - 1);
    localparam logic [4:0] LAST_J = 5'(W - 1);
    localparam conv_pkg::addr_t LAST_IDX = conv_pkg::addr_t'(H * W - 1);

    conv_pkg::addr_t wr_idx;
    logic at_end;

    assign at_end = (pos.i == LAST_I) && (pos.j == LAST_J);
    assign res_we = result_valid;
    assign res_waddr = wr_idx;

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            pos <= '0;
            pos_valid <= 1'b0;
            restart <= 1'b0;
            busy <= 1'b0;
            done <= 1'b0;
            wr_idx <= '0;
        end
        else
        begin
            restart <= start;
            // first position follows restart, the rest follow each window
            pos_valid <= restart || (window_valid && !at_end);
            if (start)
            begin
                busy <= 1'b1;
                done <= 1'b0;
                pos <= '0;
                wr_idx <= '0;
            end
            else
            begin
                if (window_valid && !at_end)
                begin
                    if (pos.j == LAST_J)
                    begin
                        pos.j <= '0;
                        pos.i <= pos.i + 5'd1;
                    end
                    else
                        pos.j <= pos.j + 5'd1;
                end
                if (result_valid)
                begin
                    wr_idx <= wr_idx + 1'b1;
                    if (wr_idx == LAST_IDX)
                    begin
                        busy <= 1'b0;
                        done <= 1'b1;
                    end
                end
            end
        end
    end

endmodule

// File: logic/conv_pkg.sv
package conv_pkg;

    // image size is bounded by this, 1024 pixels max
    parameter int ADDR_W = 10;

    typedef logic [ADDR_W-1:0] addr_t;

    typedef logic [7:0] pixel_t;          // greyscale, unsigned
    typedef logic signed [7:0] weight_t;
    typedef logic signed [19:0] result_t; // 9 * 255 * -128 fits

    // slot 0 top left, row-major
    typedef weight_t [8:0] kernel_t;
    typedef pixel_t [8:0] window_t;

    typedef struct packed {
        logic  valid;  // 0 when neighbour is padding
        addr_t addr;
    } tap_t;

    typedef struct packed {
        logic       full;  // new row, fetch all nine
        tap_t [8:0] taps;
    } patch_t;

    typedef struct packed {
        logic [4:0] i;  // row
        logic [4:0] j;  // column
    } pos_t;

endpackage

// File: logic/conv_top.sv
`timescale 1ns/1ps

module conv_top
#(
    parameter int H = 28,
    parameter int W = 28
)
(
    input  logic        clk,
    input  logic        rst,
    input  logic        cyc,
    input  logic        stb,
    input  logic        we,
    input  logic [11:0] adr,
    input  logic [31:0] dat_i,
    output logic [31:0] dat_o,
    output logic        ack
);

    logic img_we;
    conv_pkg::addr_t img_waddr;
    conv_pkg::pixel_t img_wdata;
    conv_pkg::addr_t img_raddr;
    conv_pkg::pixel_t img_rdata;

    logic res_we;
    conv_pkg::addr_t res_waddr;
    conv_pkg::addr_t res_raddr;
    conv_pkg::result_t res_rdata;

    conv_pkg::kernel_t kernel;
    logic start;
    logic busy;
    logic done;

    conv_pkg::pos_t pos;
    logic pos_valid;
    logic restart;
    conv_pkg::patch_t patch;
    logic patch_valid;
    conv_pkg::window_t window;
    logic window_valid;
    conv_pkg::result_t result;
    logic result_valid;

    wb_conv_regs i_regs (
        .clk(clk), .rst(rst), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
        .dat_i(dat_i), .res_rdata(res_rdata), .busy(busy), .done(done),
        .dat_o(dat_o), .ack(ack), .img_we(img_we), .img_waddr(img_waddr),
        .img_wdata(img_wdata), .res_raddr(res_raddr), .kernel(kernel), .start(start)
    );

    conv_ctrl #(.H(H), .W(W)) i_ctrl (
        .clk(clk), .rst(rst), .start(start), .window_valid(window_valid),
        .result_valid(result_valid), .pos(pos), .pos_valid(pos_valid),
        .restart(restart), .res_we(res_we), .res_waddr(res_waddr),
        .busy(busy), .done(done)
    );

    patch_addr_gen #(.H(H), .W(W)) i_addr_gen (
        .clk(clk), .rst(rst), .pos_valid(pos_valid), .pos(pos), .restart(restart),
        .patch(patch), .patch_valid(patch_valid)
    );

    window_fetch i_fetch (
        .clk(clk), .rst(rst), .patch(patch), .patch_valid(patch_valid),
        .rdata(img_rdata), .raddr(img_raddr), .window(window),
        .window_valid(window_valid)
    );

    mac_unit i_mac (
        .clk(clk), .rst(rst), .window(window), .window_valid(window_valid),
        .kernel(kernel), .result(result), .result_valid(result_valid)
    );

    // image pixels
    dual_port_ram #(.DEPTH(H * W), .payload_t(conv_pkg::pixel_t)) i_img_ram (
        .clk(clk), .we(img_we), .waddr(img_waddr), .wdata(img_wdata),
        .raddr(img_raddr), .rdata(img_rdata)
    );

    // convolution results, read back by the host
    dual_port_ram #(.DEPTH(H * W), .payload_t(conv_pkg::result_t)) i_res_ram (
        .clk(clk), .we(res_we), .waddr(res_waddr), .wdata(result),
        .raddr(res_raddr), .rdata(res_rdata)
    );

endmodule

// File: logic/dual_port_ram.sv
`timescale 1ns/1ps

module dual_port_ram
#(
    parameter int DEPTH = 784,
    parameter type payload_t = logic [7:0]
)
(
    input  logic            clk,
    input  logic            we,
    input  conv_pkg::addr_t waddr,
    input  payload_t        wdata,
    input  conv_pkg::addr_t raddr,
    output payload_t        rdata
);

    payload_t mem [DEPTH];

    always_ff @(posedge clk)
    begin
        if (we)
            mem[waddr] <= wdata;
        rdata <= mem[raddr];  // one cycle read latency
    end

endmodule

// File: logic/mac_unit.sv
`timescale 1ns/1ps

module mac_unit
(
    input  logic              clk,
    input  logic              rst,
    input  conv_pkg::window_t window,
    input  logic              window_valid,
    input  conv_pkg::kernel_t kernel,
    output conv_pkg::result_t result,
    output logic              result_valid
);

    conv_pkg::result_t sum;

    // pixel is zero-extended, weight sign-extended, all at result width
    always_comb
    begin
        sum = '0;
        for (int k = 0; k < 9; k++)
        begin
            sum = sum + conv_pkg::result_t'({1'b0, window[k]})
                      * conv_pkg::result_t'($signed(kernel[k]));
        end
    end

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
            result_valid <= 1'b0;
        else
            result_valid <= window_valid;
    end

    always_ff @(posedge clk)
    begin
        if (window_valid)
            result <= sum;
    end

endmodule

// File: logic/patch_addr_gen.sv
`timescale 1ns/1ps

module patch_addr_gen
#(
    parameter int H = 28,
    parameter int W = 28
)
(
    input  logic             clk,
    input  logic             rst,
    input  logic             pos_valid,
    input  conv_pkg::pos_t   pos,
    input  logic             restart,
    output conv_pkg::patch_t patch,
    output logic             patch_valid
);

    // i is only 5 bits wide, so this row never matches
    localparam logic [5:0] NO_ROW = 6'h3f;

    logic [5:0] prev_row;
    conv_pkg::patch_t nxt;

    // neighbours of (i, j) with padding 1
    always_comb
    begin
        int row;
        int col;
        nxt = '0;
        nxt.full = ({1'b0, pos.i} != prev_row);
        for (int r = 0; r < 3; r++)
        begin
            for (int c = 0; c < 3; c++)
            begin
                row = int'(pos.i) + r - 1;
                col = int'(pos.j) + c - 1;
                if (row >= 0 && row < H && col >= 0 && col < W)
                begin
                    nxt.taps[r*3 + c].valid = 1'b1;
                    nxt.taps[r*3 + c].addr = conv_pkg::addr_t'(row * W + col);
                end
                // out of image stays invalid with address 0
            end
        end
    end

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            prev_row <= NO_ROW;
            patch_valid <= 1'b0;
        end
        else
        begin
            patch_valid <= pos_valid;
            if (restart)
                prev_row <= NO_ROW;  // next request is a full load
            else if (pos_valid)
                prev_row <= {1'b0, pos.i};
        end
    end

    always_ff @(posedge clk)
    begin
        if (pos_valid)
            patch <= nxt;
    end

endmodule

// File: logic/wb_conv_regs.sv
`timescale 1ns/1ps

module wb_conv_regs
(
    input  logic              clk,
    input  logic              rst,
    input  logic              cyc,
    input  logic              stb,
    input  logic              we,
    input  logic [11:0]       adr,
    input  logic [31:0]       dat_i,
    input  conv_pkg::result_t res_rdata,
    input  logic              busy,
    input  logic              done,
    output logic [31:0]       dat_o,
    output logic              ack,
    output logic              img_we,
    output conv_pkg::addr_t   img_waddr,
    output conv_pkg::pixel_t  img_wdata,
    output conv_pkg::addr_t   res_raddr,
    output conv_pkg::kernel_t kernel,
    output logic              start
);

    localparam logic [1:0] SEL_IMG = 2'd0;
    localparam logic [1:0] SEL_RES = 2'd1;
    localparam logic [1:0] SEL_KER = 2'd2;
    localparam logic [1:0] SEL_CSR = 2'd3;

    logic req;
    logic wr;
    logic [3:0] slot;
    logic slot_ok;

    assign req = cyc && stb && !ack;  // new access, ack follows next cycle
    assign wr = req && we;
    assign slot = adr[3:0];
    assign slot_ok = (slot < 4'd9);

    // image writes are dropped while a run is busy
    assign img_we = wr && (adr[11:10] == SEL_IMG) && !busy;
    assign img_waddr = adr[conv_pkg::ADDR_W-1:0];
    assign img_wdata = dat_i[7:0];
    assign res_raddr = adr[conv_pkg::ADDR_W-1:0];  // adr held through ack
    assign start = wr && (adr[11:10] == SEL_CSR) && !adr[0] && dat_i[0] && !busy;

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            ack <= 1'b0;
            kernel <= '0;
        end
        else
        begin
            ack <= req;
            if (wr && (adr[11:10] == SEL_KER) && slot_ok)
                kernel[slot] <= conv_pkg::weight_t'(dat_i[7:0]);
        end
    end

    // result RAM data is valid in the ack cycle
    always_comb
    begin
        dat_o = '0;
        case (adr[11:10])
            SEL_RES: dat_o = {{12{res_rdata[19]}}, res_rdata};
            SEL_KER:
            begin
                if (slot_ok)
                    dat_o = {{24{kernel[slot][7]}}, kernel[slot]};
            end
            SEL_CSR:
            begin
                if (adr[0])
                    dat_o = {30'd0, done, busy};
            end
            default: dat_o = '0;  // image RAM is write only
        endcase
    end

endmodule

// File: logic/window_fetch.sv
`timescale 1ns/1ps

module window_fetch
(
    input  logic              clk,
    input  logic              rst,
    input  conv_pkg::patch_t  patch,
    input  logic              patch_valid,
    input  conv_pkg::pixel_t  rdata,
    output conv_pkg::addr_t   raddr,
    output conv_pkg::window_t window,
    output logic              window_valid
);

    logic active;
    logic full;
    conv_pkg::tap_t [8:0] taps;
    logic [3:0] step;
    logic [3:0] slot;
    logic last;

    // read pipeline, one cycle behind the issue
    logic cap_en;
    logic cap_last;
    logic cap_ok;
    logic [3:0] cap_slot;

    // full load walks 0..8, otherwise only the right column 2, 5, 8
    assign slot = full ? step : 4'(step * 3 + 2);
    assign last = full ? (step == 4'd8) : (step == 4'd2);
    assign raddr = taps[slot].addr;

    always_ff @(posedge clk or negedge rst)
    begin
        if (!rst)
        begin
            active <= 1'b0;
            step <= '0;
            cap_en <= 1'b0;
            cap_last <= 1'b0;
            window_valid <= 1'b0;
        end
        else
        begin
            cap_en <= active;
            cap_last <= active && last;
            window_valid <= cap_last;  // last pixel landed
            if (patch_valid)
            begin
                active <= 1'b1;
                step <= '0;
            end
            else if (active)
            begin
                if (last)
                    active <= 1'b0;
                else
                    step <= step + 4'd1;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (patch_valid)
        begin
            full <= patch.full;
            taps <= patch.taps;
            // slide left by one column before the new one arrives
            if (!patch.full)
            begin
                for (int r = 0; r < 3; r++)
                begin
                    window[r*3] <= window[r*3 + 1];
                    window[r*3 + 1] <= window[r*3 + 2];
                end
            end
        end
        cap_slot <= slot;
        cap_ok <= taps[slot].valid;
        if (cap_en)
            window[cap_slot] <= cap_ok ? rdata : '0;  // padding reads zero
    end

endmodule
